//--- src/matrix_input_config.svh
// Widths and ASCII codes for the matrix entry front end
// Elements saturate at 255 and the dump prints only the low nibble of each
`ifndef MATRIX_INPUT_CONFIG_SVH
`define MATRIX_INPUT_CONFIG_SVH

// ==============================
// Widths
// ==============================
`define ELEMENT_WIDTH 8
`define ADDR_WIDTH    8
// M, N and slot numbers
`define DIM_WIDTH     4
`define COUNT_WIDTH   8

// ==============================
// ASCII codes
// ==============================
`define CH_SPACE 8'h20
`define CH_CR    8'h0D
`define CH_LF    8'h0A
`define CH_ZERO  8'h30
`define CH_BANG  8'h21

`endif

//--- src/matrix_input_pkg.sv
// Shared types for the matrix entry front end
// Token kinds and error codes are fixed encodings seen by the testbench
`default_nettype none

`include "matrix_input_config.svh"

package matrix_input_pkg;

    typedef logic [`ELEMENT_WIDTH-1:0] elem_t;
    typedef logic [`ADDR_WIDTH-1:0]    addr_t;
    typedef logic [`DIM_WIDTH-1:0]     dim_t;
    typedef logic [`COUNT_WIDTH-1:0]   count_t;

    // What ended a run of characters
    typedef enum logic [1:0] {
        NUM_SEP = 2'd0,
        NUM_EOL = 2'd1,
        EOL     = 2'd2,
        BAD     = 2'd3
    } token_kind_e;

    typedef enum logic [3:0] {
        ERR_NONE        = 4'd0,
        ERR_DIM_RANGE   = 4'd1,
        ERR_VALUE_RANGE = 4'd2,
        ERR_BAD_CHAR    = 4'd3
    } err_code_e;

endpackage

`default_nettype wire

//--- src/reply_if.sv
// Reply requests from the entry sequencer to the UART formatter
// Dump levels need only be valid while dump_start is high
`timescale 1ns/1ps
`default_nettype none

interface reply_if;
    import matrix_input_pkg::*;

    logic  bang;
    logic  dump_start;
    addr_t dump_base;
    dim_t  dump_m;
    dim_t  dump_n;
    // High while a dump is being sent
    logic  dump_busy;

    modport seq (output bang, dump_start, dump_base, dump_m, dump_n, input dump_busy);
    modport fmt (input bang, dump_start, dump_base, dump_m, dump_n, output dump_busy);

endinterface

`default_nettype wire

//--- src/token_scanner.sv
// Turns the received character stream into number and separator tokens
// Numbers saturate at 255, a lone space makes no token
// One token at most per received character
`timescale 1ns/1ps
`default_nettype none

`include "matrix_input_config.svh"

module token_scanner (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic                      mode_active,
    input  wire logic [7:0]                rx_data,
    input  wire logic                      rx_done,
    output logic                           tok_valid,
    output matrix_input_pkg::token_kind_e  tok_kind,
    output matrix_input_pkg::elem_t        tok_value
);
    import matrix_input_pkg::*;

    localparam int unsigned ACC_W = `ELEMENT_WIDTH + 4;

    logic             is_digit;
    logic             is_space;
    logic             is_eol;
    logic [ACC_W-1:0] acc_next;
    elem_t            acc;
    logic             have_digits;

    assign is_digit = (rx_data >= `CH_ZERO) && (rx_data <= `CH_ZERO + 8'd9);
    assign is_space = rx_data == `CH_SPACE;
    assign is_eol   = (rx_data == `CH_CR) || (rx_data == `CH_LF);

    // Low nibble of an ASCII digit is its value
    assign acc_next = ACC_W'(acc) * ACC_W'(10) + ACC_W'(rx_data[3:0]);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tok_valid   <= 1'b0;
            acc         <= '0;
            have_digits <= 1'b0;
        end else if (!mode_active) begin
            tok_valid   <= 1'b0;
            acc         <= '0;
            have_digits <= 1'b0;
        end else begin
            tok_valid <= rx_done && !is_digit && (have_digits || !is_space);
            if (rx_done) begin
                if (is_digit) begin
                    acc <= (|acc_next[ACC_W-1:`ELEMENT_WIDTH]) ? '1
                                                              : acc_next[`ELEMENT_WIDTH-1:0];
                    have_digits <= 1'b1;
                end else begin
                    acc         <= '0;
                    have_digits <= 1'b0;
                end
            end
        end
    end

    // Token payload, qualified by tok_valid
    always_ff @(posedge clk) begin
        if (rx_done && !is_digit) begin
            tok_value <= acc;
            if (is_space) begin
                tok_kind <= NUM_SEP;
            end else if (is_eol) begin
                tok_kind <= have_digits ? NUM_EOL : EOL;
            end else begin
                tok_kind <= BAD;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/entry_sequencer.sv
// Entry FSM: dimensions, allocation, element writes, zero fill and commit
// alloc_req is a level held until alloc_valid, there is no allocation timeout
// Out-of-range numbers are dropped whole and answered with a bang
`timescale 1ns/1ps
`default_nettype none

`include "matrix_input_config.svh"

module entry_sequencer (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic                      mode_active,
    input  wire matrix_input_pkg::dim_t    config_max_dim,
    input  wire logic [3:0]                config_max_value,
    input  wire logic                      tok_valid,
    input  wire matrix_input_pkg::token_kind_e tok_kind,
    input  wire matrix_input_pkg::elem_t   tok_value,
    input  wire logic                      alloc_valid,
    input  wire matrix_input_pkg::dim_t    alloc_slot,
    input  wire matrix_input_pkg::addr_t   alloc_addr,
    output logic                           alloc_req,
    output matrix_input_pkg::dim_t         alloc_m,
    output matrix_input_pkg::dim_t         alloc_n,
    output logic                           commit_req,
    output matrix_input_pkg::dim_t         commit_slot,
    output matrix_input_pkg::dim_t         commit_m,
    output matrix_input_pkg::dim_t         commit_n,
    output matrix_input_pkg::addr_t        commit_addr,
    output logic                           mem_wr_en,
    output matrix_input_pkg::addr_t        mem_wr_addr,
    output matrix_input_pkg::elem_t        mem_wr_data,
    output matrix_input_pkg::err_code_e    error_code,
    reply_if.seq                           rpl
);
    import matrix_input_pkg::*;

    typedef enum logic [2:0] {
        S_PARSE_M, S_PARSE_N, S_WAIT_ALLOC, S_PARSE_DATA, S_FILL, S_COMMIT, S_WAIT_DUMP
    } seq_state_e;

    seq_state_e state;
    count_t     wr_count;
    count_t     total;
    dim_t       dim_m;
    dim_t       dim_n;
    dim_t       slot;
    addr_t      base;

    logic tok_num;
    logic dim_ok;
    logic val_ok;
    logic take_m;
    logic take_n;
    logic take_grant;
    logic wr_value;
    logic wr_zero;
    logic wr_fire;

    assign tok_num    = tok_valid && (tok_kind == NUM_SEP || tok_kind == NUM_EOL);
    assign dim_ok     = (tok_value != '0) && (tok_value <= elem_t'(config_max_dim));
    assign val_ok     = tok_value <= elem_t'(config_max_value);
    assign take_m     = (state == S_PARSE_M) && tok_num && dim_ok;
    assign take_n     = (state == S_PARSE_N) && tok_num && dim_ok;
    assign take_grant = (state == S_WAIT_ALLOC) && alloc_valid;
    assign wr_value   = (state == S_PARSE_DATA) && tok_num && val_ok;
    assign wr_zero    = state == S_FILL;
    assign wr_fire    = wr_value || wr_zero;

    // Descriptor levels stay put until the next entry
    assign alloc_m       = dim_m;
    assign alloc_n       = dim_n;
    assign commit_slot   = slot;
    assign commit_m      = dim_m;
    assign commit_n      = dim_n;
    assign commit_addr   = base;
    assign rpl.dump_base = base;
    assign rpl.dump_m    = dim_m;
    assign rpl.dump_n    = dim_n;

    always_ff @(posedge clk) begin
        if (take_m) begin
            dim_m <= tok_value[`DIM_WIDTH-1:0];
        end
        if (take_n) begin
            dim_n <= tok_value[`DIM_WIDTH-1:0];
            total <= count_t'(dim_m) * count_t'(tok_value[`DIM_WIDTH-1:0]);
        end
        if (take_grant) begin
            base <= alloc_addr;
            slot <= alloc_slot;
        end
        if (wr_fire) begin
            mem_wr_addr <= base + addr_t'(wr_count);
            mem_wr_data <= wr_value ? tok_value : '0;
        end
    end

    // ==============================
    // Control FSM
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= S_PARSE_M;
            wr_count       <= '0;
            alloc_req      <= 1'b0;
            commit_req     <= 1'b0;
            mem_wr_en      <= 1'b0;
            rpl.bang       <= 1'b0;
            rpl.dump_start <= 1'b0;
            error_code     <= ERR_NONE;
        end else if (!mode_active) begin
            state          <= S_PARSE_M;
            wr_count       <= '0;
            alloc_req      <= 1'b0;
            commit_req     <= 1'b0;
            mem_wr_en      <= 1'b0;
            rpl.bang       <= 1'b0;
            rpl.dump_start <= 1'b0;
            error_code     <= ERR_NONE;
        end else begin
            mem_wr_en      <= wr_fire;
            commit_req     <= 1'b0;
            rpl.bang       <= 1'b0;
            rpl.dump_start <= 1'b0;
            if (wr_fire) begin
                wr_count <= wr_count + 1'b1;
            end

            case (state)
                S_PARSE_M, S_PARSE_N: begin
                    // Blank lines between entries are skipped
                    if (tok_valid && tok_kind != EOL) begin
                        if (tok_kind == BAD || !dim_ok) begin
                            error_code <= ERR_DIM_RANGE;
                            rpl.bang   <= 1'b1;
                            state      <= S_PARSE_M;
                        end else if (state == S_PARSE_M) begin
                            state <= S_PARSE_N;
                        end else begin
                            alloc_req <= 1'b1;
                            state     <= S_WAIT_ALLOC;
                        end
                    end
                end
                S_WAIT_ALLOC: begin
                    if (alloc_valid) begin
                        alloc_req <= 1'b0;
                        wr_count  <= '0;
                        state     <= S_PARSE_DATA;
                    end
                end
                S_PARSE_DATA: begin
                    if (tok_valid) begin
                        if (tok_kind == BAD) begin
                            error_code <= ERR_BAD_CHAR;
                            rpl.bang   <= 1'b1;
                        end else if (tok_num && !val_ok) begin
                            error_code <= ERR_VALUE_RANGE;
                            rpl.bang   <= 1'b1;
                        end else begin
                            if (tok_num) begin
                                error_code <= ERR_NONE;
                            end
                            if (tok_num && (wr_count + 1'b1 == total)) begin
                                state <= S_COMMIT;
                            end else if (tok_kind != NUM_SEP) begin
                                // Early Enter, pad the rest with zeros
                                state <= S_FILL;
                            end
                        end
                    end
                end
                S_FILL: begin
                    if (wr_count + 1'b1 == total) begin
                        state <= S_COMMIT;
                    end
                end
                S_COMMIT: begin
                    // Last write is on the bus this cycle
                    commit_req     <= 1'b1;
                    rpl.dump_start <= 1'b1;
                    state          <= S_WAIT_DUMP;
                end
                S_WAIT_DUMP: begin
                    // dump_busy rises one cycle after dump_start
                    if (!rpl.dump_start && !rpl.dump_busy) begin
                        state <= S_PARSE_M;
                    end
                end
                default: state <= S_PARSE_M;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/reply_formatter.sv
// Sends the "!" echo and the stored matrix dump over the UART transmitter
// Memory read data must follow the address by one cycle
// A dump_start while a dump is running is ignored
`timescale 1ns/1ps
`default_nettype none

`include "matrix_input_config.svh"

module reply_formatter (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     tx_busy,
    input  wire matrix_input_pkg::elem_t  mem_rd_data,
    output logic [7:0]                    tx_data,
    output logic                          tx_start,
    output matrix_input_pkg::addr_t       mem_rd_addr,
    reply_if.fmt                          rpl
);
    import matrix_input_pkg::*;

    typedef enum logic [2:0] {
        F_IDLE, F_CR, F_LF, F_READ, F_DIGIT, F_SPACE, F_END_CR, F_END_LF
    } fmt_step_e;

    fmt_step_e  step;
    logic       bang_pending;
    dim_t       row;
    dim_t       col;
    addr_t      base_r;
    dim_t       m_r;
    dim_t       n_r;
    logic       can_send;
    logic       send;
    logic [7:0] send_char;

    // One character per free transmitter slot
    assign can_send      = !tx_busy && !tx_start;
    assign rpl.dump_busy = step != F_IDLE;
    assign mem_rd_addr   = base_r + addr_t'(row) * addr_t'(n_r) + addr_t'(col);

    always_comb begin
        send      = 1'b0;
        send_char = `CH_CR;
        case (step)
            F_IDLE: begin
                send      = bang_pending && !rpl.dump_start;
                send_char = `CH_BANG;
            end
            F_CR, F_END_CR: send = 1'b1;
            F_LF, F_END_LF: begin
                send      = 1'b1;
                send_char = `CH_LF;
            end
            F_DIGIT: begin
                send      = 1'b1;
                send_char = `CH_ZERO + {4'b0000, mem_rd_data[3:0]};
            end
            F_SPACE: begin
                send      = 1'b1;
                send_char = `CH_SPACE;
            end
            default: send = 1'b0;
        endcase
        send = send && can_send;
    end

    always_ff @(posedge clk) begin
        if (rpl.dump_start && step == F_IDLE) begin
            base_r <= rpl.dump_base;
            m_r    <= rpl.dump_m;
            n_r    <= rpl.dump_n;
        end
        if (send) begin
            tx_data <= send_char;
        end
    end

    // ==============================
    // Dump walk
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_start     <= 1'b0;
            bang_pending <= 1'b0;
            step         <= F_IDLE;
            row          <= '0;
            col          <= '0;
        end else begin
            tx_start <= send;
            // A second bang while one waits is folded into it
            if (send && step == F_IDLE) begin
                bang_pending <= 1'b0;
            end else if (rpl.bang) begin
                bang_pending <= 1'b1;
            end

            case (step)
                F_IDLE: begin
                    if (rpl.dump_start) begin
                        row  <= '0;
                        col  <= '0;
                        step <= F_CR;
                    end
                end
                F_CR:   if (send) step <= F_LF;
                F_LF:   if (send) step <= F_READ;
                // Address settles here, data is valid next cycle
                F_READ: step <= F_DIGIT;
                F_DIGIT: begin
                    if (send) begin
                        if (col == n_r - 1'b1) begin
                            col <= '0;
                            if (row == m_r - 1'b1) begin
                                step <= F_END_CR;
                            end else begin
                                row  <= row + 1'b1;
                                step <= F_CR;
                            end
                        end else begin
                            step <= F_SPACE;
                        end
                    end
                end
                F_SPACE: begin
                    if (send) begin
                        col  <= col + 1'b1;
                        step <= F_READ;
                    end
                end
                F_END_CR: if (send) step <= F_END_LF;
                F_END_LF: if (send) step <= F_IDLE;
                default:  step <= F_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/matrix_input_top.sv
// Matrix entry front end between a UART and a matrix manager
// Memory read is synchronous with one cycle of latency
// Element values are bounded by config_max_value, dimensions by config_max_dim
`timescale 1ns/1ps
`default_nettype none

module matrix_input_top (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     mode_active,
    input  wire matrix_input_pkg::dim_t   config_max_dim,
    input  wire logic [3:0]               config_max_value,
    input  wire logic [7:0]               rx_data,
    input  wire logic                     rx_done,
    output logic [7:0]                    tx_data,
    output logic                          tx_start,
    input  wire logic                     tx_busy,
    output logic                          alloc_req,
    output matrix_input_pkg::dim_t        alloc_m,
    output matrix_input_pkg::dim_t        alloc_n,
    input  wire logic                     alloc_valid,
    input  wire matrix_input_pkg::dim_t   alloc_slot,
    input  wire matrix_input_pkg::addr_t  alloc_addr,
    output logic                          commit_req,
    output matrix_input_pkg::dim_t        commit_slot,
    output matrix_input_pkg::dim_t        commit_m,
    output matrix_input_pkg::dim_t        commit_n,
    output matrix_input_pkg::addr_t       commit_addr,
    output logic                          mem_wr_en,
    output matrix_input_pkg::addr_t       mem_wr_addr,
    output matrix_input_pkg::elem_t       mem_wr_data,
    output matrix_input_pkg::addr_t       mem_rd_addr,
    input  wire matrix_input_pkg::elem_t  mem_rd_data,
    output matrix_input_pkg::err_code_e   error_code
);
    import matrix_input_pkg::*;

    // Scanner to sequencer tokens
    logic        tok_valid;
    token_kind_e tok_kind;
    elem_t       tok_value;

    reply_if rpl ();

    token_scanner u_scanner (.*);

    entry_sequencer u_sequencer (.*);

    reply_formatter u_formatter (.*);

endmodule

`default_nettype wire

//--- tests/tb_matrix_input.sv
// Testbench for the matrix entry front end
// Models a UART transmitter, a matrix manager granting slot 2 at address 16
// and a block memory with one cycle of read latency
// Dimensions are limited to 5 and element values to 9
`timescale 1ns/1ps
`default_nettype none

`include "matrix_input_config.svh"

module tb_matrix_input;
    import matrix_input_pkg::*;

    localparam int TIMEOUT_CYCLES = 4000;
    localparam int GRANT_SLOT     = 2;
    localparam int GRANT_ADDR     = 16;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       mode_active;
    dim_t       config_max_dim;
    logic [3:0] config_max_value;
    logic [7:0] rx_data;
    logic       rx_done;
    logic [7:0] tx_data;
    logic       tx_start;
    logic       tx_busy = 1'b0;
    logic       alloc_req;
    dim_t       alloc_m;
    dim_t       alloc_n;
    logic       alloc_valid = 1'b0;
    dim_t       alloc_slot = '0;
    addr_t      alloc_addr = '0;
    logic       commit_req;
    dim_t       commit_slot;
    dim_t       commit_m;
    dim_t       commit_n;
    addr_t      commit_addr;
    logic       mem_wr_en;
    addr_t      mem_wr_addr;
    elem_t      mem_wr_data;
    addr_t      mem_rd_addr;
    elem_t      mem_rd_data = '0;
    err_code_e  error_code;

    logic [7:0] lfsr_state = 8'd40;
    elem_t      mem [0:255];
    addr_t      rd_addr_q = '0;
    logic [7:0] tx_expect [$];
    int         wr_expect [$];
    int         entry_vals [0:15];
    int         digits [0:5];
    int         busy_left = 0;
    int         grant_wait = 0;
    logic       alloc_seen = 1'b0;
    int         grant_count = 0;
    int         grants_wanted = 0;
    int         alloc_count = 0;
    int         commit_count = 0;
    int         exp_m = 0;
    int         exp_n = 0;
    int         error_count = 0;
    int         cycle_count = 0;
    int         tests_passed = 0;
    int         tests_failed = 0;
    int         test_error_base = 0;
    int         alloc_base = 0;
    int         commit_base = 0;
    int         wr_word;
    logic [7:0] tx_char;

    matrix_input_top dut (.*);

    always #5 clk = ~clk;

    // ==============================
    // Helpers
    // ==============================
    // Galois LFSR, x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic next_random_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 8'hB8;
        end
        return out;
    endfunction

    function automatic int random_bits(input int count);
        int value;
        value = 0;
        for (int i = 0; i < count; i++) begin
            value = (value << 1) | int'(next_random_bit());
        end
        return value;
    endfunction

    task automatic expect_equal(input logic [31:0] got, input int exp, input string what);
        assert (got == exp) else begin
            $display("[FAIL] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic check_quiet();
        expect_equal(tx_start, 0, "tx_start");
        expect_equal(alloc_req, 0, "alloc_req");
        expect_equal(commit_req, 0, "commit_req");
        expect_equal(mem_wr_en, 0, "mem_wr_en");
        expect_equal(error_code, ERR_NONE, "error_code");
    endtask

    task automatic send_char(input logic [7:0] c);
        @(negedge clk);
        rx_data = c;
        rx_done = 1'b1;
        @(negedge clk);
        rx_done = 1'b0;
    endtask

    task automatic send_text(input string s);
        for (int i = 0; i < s.len(); i++) begin
            send_char(s[i]);
        end
    endtask

    // Data typed before the grant would be dropped
    task automatic wait_grant();
        grants_wanted++;
        while (grant_count < grants_wanted) begin
            @(negedge clk);
        end
    endtask

    task automatic wait_idle();
        while (tx_expect.size() != 0 || wr_expect.size() != 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
    endtask

    // Writes and dump for one entry, unsent elements are zero
    task automatic expect_entry(input int m, input int n, input int sent);
        int r;
        int c;
        int k;
        int v;
        for (r = 0; r < m; r++) begin
            tx_expect.push_back(`CH_CR);
            tx_expect.push_back(`CH_LF);
            for (c = 0; c < n; c++) begin
                k = r * n + c;
                v = (k < sent) ? entry_vals[k] : 0;
                wr_expect.push_back(((GRANT_ADDR + k) << 8) | v);
                if (c != 0) begin
                    tx_expect.push_back(`CH_SPACE);
                end
                tx_expect.push_back(`CH_ZERO + 8'(v % 16));
            end
        end
        tx_expect.push_back(`CH_CR);
        tx_expect.push_back(`CH_LF);
    endtask

    task automatic begin_test();
        test_error_base = error_count;
        alloc_base = alloc_count;
        commit_base = commit_count;
    endtask

    task automatic end_test(input string name, input int allocs, input int commits);
        expect_equal(alloc_count - alloc_base, allocs, "alloc requests");
        expect_equal(commit_count - commit_base, commits, "commit pulses");
        expect_equal(error_code, ERR_NONE, "error_code at end of test");
        if (error_count == test_error_base) begin
            tests_passed++;
            $display("Test %s: passed", name);
        end else begin
            tests_failed++;
            $display("Test %s: failed with %0d errors", name, error_count - test_error_base);
        end
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the DUT stopped responding", cycle_count);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // ==============================
    // Models
    // ==============================
    always @(negedge clk) begin
        // UART transmitter, busy for 2 to 5 cycles per character
        if (tx_start) begin
            assert (tx_expect.size() != 0) else begin
                $display("Unexpected character 0x%02h sent on the UART at %0t ns",
                         tx_data, $time);
                error_count++;
            end
            if (tx_expect.size() != 0) begin
                tx_char = tx_expect.pop_front();
                expect_equal(tx_data, tx_char, "transmitted character");
            end
            busy_left = 2 + random_bits(2);
        end else if (busy_left != 0) begin
            busy_left--;
        end
        tx_busy = busy_left != 0;

        // Matrix manager
        if (alloc_valid) begin
            alloc_valid = 1'b0;
        end else if (alloc_req) begin
            if (!alloc_seen) begin
                alloc_seen = 1'b1;
                alloc_count++;
                expect_equal(alloc_m, exp_m, "alloc_m");
                expect_equal(alloc_n, exp_n, "alloc_n");
                grant_wait = random_bits(2);
            end else if (grant_wait != 0) begin
                grant_wait--;
            end else begin
                alloc_valid = 1'b1;
                alloc_slot = dim_t'(GRANT_SLOT);
                alloc_addr = addr_t'(GRANT_ADDR);
                alloc_seen = 1'b0;
                grant_count++;
            end
        end

        if (commit_req) begin
            commit_count++;
            expect_equal(commit_slot, GRANT_SLOT, "commit_slot");
            expect_equal(commit_addr, GRANT_ADDR, "commit_addr");
            expect_equal(commit_m, exp_m, "commit_m");
            expect_equal(commit_n, exp_n, "commit_n");
            expect_equal(wr_expect.size(), 0, "writes left at commit");
        end

        // Block memory, write first, read data follows its address by one cycle
        if (mem_wr_en) begin
            assert (wr_expect.size() != 0) else begin
                $display("Unexpected memory write of %0d to address %0d at %0t ns",
                         mem_wr_data, mem_wr_addr, $time);
                error_count++;
            end
            if (wr_expect.size() != 0) begin
                wr_word = wr_expect.pop_front();
                expect_equal(mem_wr_addr, wr_word >> 8, "write address");
                expect_equal(mem_wr_data, wr_word & 255, "write data");
            end
            mem[mem_wr_addr] = mem_wr_data;
        end
        mem_rd_data = mem[rd_addr_q];
        rd_addr_q = mem_rd_addr;
    end

    // ==============================
    // Stimulus
    // ==============================
    initial begin : stimulus
        int i;
        rst_n = 1'b0;
        mode_active = 1'b0;
        config_max_dim = dim_t'(5);
        config_max_value = 4'd9;
        rx_data = 8'h00;
        rx_done = 1'b0;
        for (i = 0; i < 256; i++) begin
            mem[i] = elem_t'(i) ^ 8'hA5;
        end
        for (i = 0; i < 6; i++) begin
            digits[i] = random_bits(4) % 10;
        end

        // Reset, then characters while the mode is off
        begin_test();
        repeat (3) begin
            @(negedge clk);
            check_quiet();
        end
        rst_n = 1'b1;
        send_text("1 1 ");
        repeat (3) begin
            @(negedge clk);
            check_quiet();
        end
        end_test("reset and idle", 0, 0);
        mode_active = 1'b1;

        begin_test();
        exp_m = 2;
        exp_n = 3;
        for (i = 0; i < 6; i++) begin
            entry_vals[i] = digits[i];
        end
        expect_entry(2, 3, 6);
        send_text("2 3 ");
        wait_grant();
        for (i = 0; i < 6; i++) begin
            send_char(`CH_ZERO + 8'(digits[i]));
            send_char(`CH_SPACE);
        end
        wait_idle();
        end_test("full entry", 1, 1);

        begin_test();
        exp_m = 2;
        exp_n = 2;
        entry_vals[0] = 7;
        expect_entry(2, 2, 1);
        send_text("2 2 ");
        wait_grant();
        send_text("7");
        send_char(`CH_CR);
        wait_idle();
        end_test("early enter", 1, 1);

        // Each pair fails on N, so parsing restarts at M
        begin_test();
        exp_m = 1;
        exp_n = 1;
        tx_expect.push_back(`CH_BANG);
        send_text("3 0 ");
        wait_idle();
        expect_equal(error_code, ERR_DIM_RANGE, "error_code after N of 0");
        tx_expect.push_back(`CH_BANG);
        send_text("2 6 ");
        wait_idle();
        expect_equal(error_code, ERR_DIM_RANGE, "error_code after N of 6");
        expect_equal(alloc_count - alloc_base, 0, "alloc requests after bad dimensions");
        entry_vals[0] = 4;
        expect_entry(1, 1, 1);
        send_text("1 1 ");
        wait_grant();
        send_text("4 ");
        wait_idle();
        end_test("bad dimensions", 1, 1);

        begin_test();
        exp_m = 1;
        exp_n = 2;
        send_text("1 2 ");
        wait_grant();
        tx_expect.push_back(`CH_BANG);
        send_text("12 ");
        wait_idle();
        expect_equal(error_code, ERR_VALUE_RANGE, "error_code after 12");
        tx_expect.push_back(`CH_BANG);
        send_text("x");
        wait_idle();
        expect_equal(error_code, ERR_BAD_CHAR, "error_code after x");
        entry_vals[0] = 3;
        entry_vals[1] = 5;
        expect_entry(1, 2, 2);
        send_text("3 5 ");
        wait_idle();
        end_test("bad values", 1, 1);

        $display("Tests passed: %0d, failed: %0d, failed checks: %0d",
                 tests_passed, tests_failed, error_count);
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+src
src/matrix_input_pkg.sv
src/reply_if.sv
src/token_scanner.sv
src/entry_sequencer.sv
src/reply_formatter.sv
src/matrix_input_top.sv
tests/tb_matrix_input.sv

//--- Makefile
# Verilator build and run of the matrix entry testbench
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_matrix_input
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# The run passes only if the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
